/* files.f */
+incdir+verification
hdl/render_pkg.sv
hdl/background_rom.sv
hdl/sprite_rom.sv
hdl/pixel_pipe.sv
hdl/render_control.sv
hdl/render_top.sv
verification/render_tb.sv

/* verification/render_model.svh */
`ifndef RENDER_MODEL_SVH
`define RENDER_MODEL_SVH

// Sprite pictures, rows by dy and columns by dx
localparam color_t PLAYER_ART [0:4][0:4] = '{
    '{12'hF00, 12'hFF3, 12'hFF3, 12'h000, 12'hFF3},
    '{12'hFF3, 12'hFF3, 12'hFF3, 12'hFF3, 12'hFF3},
    '{12'hFF3, 12'hFF3, 12'hFF3, 12'hFF3, 12'hFF3},
    '{12'h000, 12'h000, 12'hFF3, 12'hFF3, 12'hFF3},
    '{12'hFF3, 12'hFF3, 12'hFF3, 12'h000, 12'hF00}
};

localparam color_t GHOST_ART [0:4][0:4] = '{
    '{12'h000, 12'h000, 12'hFFF, 12'h000, 12'h000},
    '{12'h000, 12'hFFF, 12'hFFF, 12'hFFF, 12'h000},
    '{12'hFFF, 12'hFFF, 12'hF00, 12'hFFF, 12'hFFF},
    '{12'hFFF, 12'hFFF, 12'hFFF, 12'hFFF, 12'hFFF},
    '{12'hFFF, 12'h000, 12'hFFF, 12'h000, 12'hFFF}
};

color_t expected [0:SCREEN_W-1][0:SCREEN_H-1];    // What the frame buffer should hold

function automatic color_t background_at(input int x, input int y);
    int   tx;
    int   ty;
    logic wall;
    tx   = x / TILE_SIZE;
    ty   = y / TILE_SIZE;
    wall = (tx == 0) || (tx == BOARD_W - 1) || (ty == 0) || (ty == BOARD_H - 1);
    wall = wall || ((tx % 4 == 2) && (ty % 4 == 2));    // Pillar grid
    if (wall)
        return COLOR_WALL;
    if ((x % TILE_SIZE == 2) && (y % TILE_SIZE == 2))
        return COLOR_PELLET;
    return COLOR_FLOOR;
endfunction

function automatic color_t sprite_at(input int obj, input int dx, input int dy);
    if (obj == 0)
        return PLAYER_ART[dy][dx];
    return GHOST_ART[dy][dx];    // All three ghosts look alike
endfunction

task automatic paint_background();
    for (int x = 0; x < SCREEN_W; x++)
        for (int y = 0; y < SCREEN_H; y++)
            expected[x][y] = background_at(x, y);
endtask

task automatic erase_block(input int tx, input int ty);
    for (int dy = 0; dy < TILE_SIZE; dy++)
        for (int dx = 0; dx < TILE_SIZE; dx++)
            expected[tx*TILE_SIZE + dx][ty*TILE_SIZE + dy] =
                background_at(tx*TILE_SIZE + dx, ty*TILE_SIZE + dy);
endtask

task automatic draw_object(input int obj, input int tx, input int ty);
    for (int dy = 0; dy < TILE_SIZE; dy++)
        for (int dx = 0; dx < TILE_SIZE; dx++)
            expected[tx*TILE_SIZE + dx][ty*TILE_SIZE + dy] = sprite_at(obj, dx, dy);
endtask

`endif

/* verification/render_tb.sv */
`timescale 1ns/1ns

module render_tb import render_pkg::*; ();

    localparam int CREDITS      = 4;
    localparam int DONE_TIMEOUT = 30000;
    localparam int IDLE_CYCLES  = 20;    // Room for a stray frame to show itself

    `include "render_model.svh"

    logic     clock;
    logic     resetn;
    logic     start;
    tile_x_t  player_x, ghost1_x, ghost2_x, ghost3_x;
    tile_y_t  player_y, ghost1_y, ghost2_y, ghost3_y;
    logic     pixel_credit;
    logic     busy;
    logic     done;
    logic     pixel_valid;
    pixel_x_t pixel_x;
    pixel_y_t pixel_y;
    color_t   pixel_color;

    color_t captured [0:SCREEN_W-1][0:SCREEN_H-1];
    color_t snapshot [0:SCREEN_W-1][0:SCREEN_H-1];
    int     credit_due [$];    // Cycle at which each credit goes back
    int     seed = 15287;
    int     credit_max_delay = 0;
    int     credit_delay;
    int     cycle = 0;
    int     pixel_total = 0;
    int     credits_returned = 0;
    int     done_count = 0;
    int     value_errors = 0;
    int     timeout_errors = 0;
    int     next_x [4];
    int     next_y [4];
    int     prev_x [4];
    int     prev_y [4];
    bit     model_painted = 1'b0;

    render_top #(.CREDITS(CREDITS)) UUT (
        .clock, .resetn, .start,
        .player_x, .player_y, .ghost1_x, .ghost1_y,
        .ghost2_x, .ghost2_y, .ghost3_x, .ghost3_y,
        .pixel_credit, .busy, .done,
        .pixel_valid, .pixel_x, .pixel_y, .pixel_color
    );

    always #5 clock = ~clock;

    // Frame buffer side: capture pixels and pay credits back
    always begin
        @(negedge clock);
        if (done === 1'b1)
            done_count++;
        if (pixel_valid === 1'b1) begin
            captured[pixel_x][pixel_y] = pixel_color;
            pixel_total++;
            credit_delay = $unsigned($random(seed)) % (credit_max_delay + 1);
            credit_due.push_back(cycle + 1 + credit_delay);
            check_flag(pixel_total - credits_returned <= CREDITS, 1'b1, "credit limit held");
        end
        @(posedge clock);
        #1;
        cycle++;
        if (credit_due.size() > 0 && credit_due[0] <= cycle) begin
            pixel_credit = 1'b1;
            void'(credit_due.pop_front());
            credits_returned++;
        end else begin
            pixel_credit = 1'b0;
        end
    end

    task automatic check_color(input color_t got, input color_t exp, input int x, input int y);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %0t: pixel (%0d,%0d) is %h, expected %h", $time, x, y, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            value_errors++;
            $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL %0t: %s, got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic place_objects(input int px, input int py, input int g1x, input int g1y,
                                 input int g2x, input int g2y, input int g3x, input int g3y);
        next_x = '{px, g1x, g2x, g3x};
        next_y = '{py, g1y, g2y, g3y};
    endtask

    task automatic update_model();
        if (!model_painted)
            paint_background();
        else
            for (int i = 0; i < 4; i++)
                erase_block(prev_x[i], prev_y[i]);
        for (int i = 0; i < 4; i++)
            draw_object(i, next_x[i], next_y[i]);    // Later objects win on overlap
        prev_x = next_x;
        prev_y = next_y;
        model_painted = 1'b1;
    endtask

    task automatic compare_image();
        for (int x = 0; x < SCREEN_W; x++)
            for (int y = 0; y < SCREEN_H; y++)
                check_color(captured[x][y], expected[x][y], x, y);
    endtask

    task automatic run_frame(input int max_delay, input int expected_pixels,
                             input bit extra_start, input string name);
        int pixels_before;
        int dones_before;
        int waited;
        bit seen_done;
        credit_max_delay = max_delay;
        update_model();
        pixels_before = pixel_total;
        dones_before  = done_count;
        @(posedge clock);
        #1;
        player_x = tile_x_t'(next_x[0]);
        player_y = tile_y_t'(next_y[0]);
        ghost1_x = tile_x_t'(next_x[1]);
        ghost1_y = tile_y_t'(next_y[1]);
        ghost2_x = tile_x_t'(next_x[2]);
        ghost2_y = tile_y_t'(next_y[2]);
        ghost3_x = tile_x_t'(next_x[3]);
        ghost3_y = tile_y_t'(next_y[3]);
        start = 1'b1;
        @(posedge clock);
        #1;
        start = 1'b0;
        @(negedge clock);
        check_flag(busy, 1'b1, "busy after start");
        if (extra_start) begin    // Should be ignored
            @(posedge clock);
            #1 start = 1'b1;
            @(posedge clock);
            #1 start = 1'b0;
        end
        waited    = 0;
        seen_done = 1'b0;
        while (!seen_done && waited < DONE_TIMEOUT) begin
            @(negedge clock);
            waited++;
            if (done === 1'b1)
                seen_done = 1'b1;
            else
                check_flag(busy, 1'b1, "busy during frame");
        end
        if (!seen_done) begin
            $display("ERROR: %s frame gave no done within %0d cycles", name, DONE_TIMEOUT);
            timeout_errors++;
        end else begin
            check_flag(busy, 1'b0, "busy falls with done");
            @(negedge clock);
            check_flag(done, 1'b0, "done is a single pulse");
        end
        repeat (IDLE_CYCLES) @(negedge clock);
        check_flag(busy, 1'b0, "idle after frame");
        check_count(done_count - dones_before, 1, {name, " done pulses"});
        check_count(pixel_total - pixels_before, expected_pixels, {name, " pixel count"});
        compare_image();
    endtask

    task automatic test_reset_state();
        @(negedge clock);
        check_flag(busy, 1'b0, "busy after reset");
        check_flag(done, 1'b0, "done after reset");
        check_flag(pixel_valid, 1'b0, "pixel_valid after reset");
    endtask

    task automatic test_first_frame();
        place_objects(1, 1, 30, 22, 15, 11, 6, 6);
        run_frame(0, SCREEN_W*SCREEN_H + 100, 1'b0, "first");
    endtask

    task automatic test_moved_objects();
        place_objects(2, 1, 15, 11, 15, 11, 3, 5);    // Ghosts 1 and 2 stacked
        run_frame(0, 200, 1'b0, "moved");
    endtask

    task automatic test_slow_credits();
        place_objects(10, 10, 10, 10, 20, 3, 31, 23);
        run_frame(3, 200, 1'b0, "slow credit");
    endtask

    task automatic test_start_while_busy();
        place_objects(11, 10, 12, 10, 20, 4, 0, 0);
        run_frame(2, 200, 1'b1, "double start");
    endtask

    task automatic test_same_positions();
        int changed;
        changed  = 0;
        snapshot = captured;
        run_frame(1, 200, 1'b0, "unchanged");
        for (int x = 0; x < SCREEN_W; x++)
            for (int y = 0; y < SCREEN_H; y++)
                if (captured[x][y] !== snapshot[x][y])
                    changed++;
        check_count(changed, 0, "pixels changed by same positions");
    endtask

    initial begin
        clock        = 1'b0;
        resetn       = 1'b0;
        start        = 1'b0;
        pixel_credit = 1'b0;
        player_x = '0;
        player_y = '0;
        ghost1_x = '0;
        ghost1_y = '0;
        ghost2_x = '0;
        ghost2_y = '0;
        ghost3_x = '0;
        ghost3_y = '0;
        repeat (2) @(posedge clock);
        #1 resetn = 1'b1;

        test_reset_state();
        test_first_frame();
        test_moved_objects();
        test_slow_credits();
        test_start_while_busy();
        test_same_positions();

        $display("Errors: %0d value, %0d timeout", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* hdl/render_top.sv */
`timescale 1ns/1ns

module render_top import render_pkg::*; #(
    parameter int CREDITS = 4           // Pixels the frame buffer accepts ahead
) (
    input  logic     clock,
    input  logic     resetn,
    input  logic     start,
    input  tile_x_t  player_x,
    input  tile_y_t  player_y,
    input  tile_x_t  ghost1_x,
    input  tile_y_t  ghost1_y,
    input  tile_x_t  ghost2_x,
    input  tile_y_t  ghost2_y,
    input  tile_x_t  ghost3_x,
    input  tile_y_t  ghost3_y,
    input  logic     pixel_credit,
    output logic     busy,
    output logic     done,
    output logic     pixel_valid,
    output pixel_x_t pixel_x,
    output pixel_y_t pixel_y,
    output color_t   pixel_color
);

    logic     req_valid;
    logic     req_ready;
    logic     pipe_empty;
    pixel_x_t req_x;
    pixel_y_t req_y;
    offset_t  req_dx;
    offset_t  req_dy;
    source_t  req_source;
    color_t   bg_color;
    color_t   sprite_color;

    render_control u_control (
        .clock, .resetn, .start,
        .player_x, .player_y,
        .ghost1_x, .ghost1_y,
        .ghost2_x, .ghost2_y,
        .ghost3_x, .ghost3_y,
        .req_ready, .pipe_empty,
        .req_valid, .req_x, .req_y, .req_dx, .req_dy, .req_source,
        .busy, .done
    );

    // Both lookups see the request in the same cycle
    background_rom u_background (
        .clock, .resetn, .req_x, .req_y, .bg_color
    );

    sprite_rom u_sprite (
        .clock, .resetn, .req_source, .req_dx, .req_dy, .sprite_color
    );

    pixel_pipe #(
        .CREDITS(CREDITS)
    ) u_pipe (
        .clock, .resetn,
        .req_valid, .req_x, .req_y, .req_source,
        .bg_color, .sprite_color, .pixel_credit,
        .req_ready, .pipe_empty,
        .pixel_valid, .pixel_x, .pixel_y, .pixel_color
    );

endmodule

/* hdl/render_control.sv */
`timescale 1ns/1ns

module render_control import render_pkg::*; (
    input  logic     clock,
    input  logic     resetn,
    input  logic     start,
    input  tile_x_t  player_x,
    input  tile_y_t  player_y,
    input  tile_x_t  ghost1_x,
    input  tile_y_t  ghost1_y,
    input  tile_x_t  ghost2_x,
    input  tile_y_t  ghost2_y,
    input  tile_x_t  ghost3_x,
    input  tile_y_t  ghost3_y,
    input  logic     req_ready,
    input  logic     pipe_empty,
    output logic     req_valid,
    output pixel_x_t req_x,
    output pixel_y_t req_y,
    output offset_t  req_dx,
    output offset_t  req_dy,
    output source_t  req_source,
    output logic     busy,
    output logic     done
);

    typedef enum logic [2:0] {
        S_IDLE, S_FILL, S_ERASE, S_DRAW, S_DRAIN, S_FINISH
    } state_t;

    state_t   state;
    logic     first_frame;           // Background not painted yet
    pixel_x_t fill_x;
    pixel_y_t fill_y;
    offset_t  dx;
    offset_t  dy;
    object_t  obj;
    logic     accept;
    logic     block_last;            // Last pixel of the current 5x5 block

    tile_x_t  pos_x_in [4];
    tile_y_t  pos_y_in [4];
    tile_x_t  cur_x [4];             // Positions of this frame
    tile_y_t  cur_y [4];
    tile_x_t  prev_x [4];            // Positions drawn by the last frame
    tile_y_t  prev_y [4];
    tile_x_t  sel_tile_x;
    tile_y_t  sel_tile_y;

    assign pos_x_in = '{player_x, ghost1_x, ghost2_x, ghost3_x};
    assign pos_y_in = '{player_y, ghost1_y, ghost2_y, ghost3_y};

    assign req_valid  = (state == S_FILL) || (state == S_ERASE) || (state == S_DRAW);
    assign accept     = req_valid && req_ready;
    assign block_last = (dx == offset_t'(TILE_SIZE - 1)) && (dy == offset_t'(TILE_SIZE - 1));

    // Erase works on where the object was, draw on where it is now
    assign sel_tile_x = (state == S_ERASE) ? prev_x[obj] : cur_x[obj];
    assign sel_tile_y = (state == S_ERASE) ? prev_y[obj] : cur_y[obj];

    always_comb begin
        if (state == S_FILL) begin
            req_x = fill_x;
            req_y = fill_y;
        end else begin
            req_x = pixel_x_t'(pixel_x_t'(sel_tile_x) * TILE_SIZE + dx);
            req_y = pixel_y_t'(pixel_y_t'(sel_tile_y) * TILE_SIZE + dy);
        end
    end

    always_comb begin
        if (state != S_DRAW)
            req_source = SRC_BACKGROUND;
        else if (obj == object_t'(0))
            req_source = SRC_PLAYER;
        else
            req_source = SRC_GHOST;
    end

    assign req_dx = dx;
    assign req_dy = dy;
    assign busy   = (state != S_IDLE) && (state != S_FINISH);
    assign done   = (state == S_FINISH);

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            state       <= S_IDLE;
            first_frame <= 1'b1;
            fill_x      <= '0;
            fill_y      <= '0;
            dx          <= '0;
            dy          <= '0;
            obj         <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start)
                        state <= first_frame ? S_FILL : S_ERASE;
                end

                S_FILL: begin
                    if (accept) begin
                        if (fill_x == pixel_x_t'(SCREEN_W - 1)) begin
                            fill_x <= '0;
                            if (fill_y == pixel_y_t'(SCREEN_H - 1)) begin
                                fill_y      <= '0;
                                first_frame <= 1'b0;
                                state       <= S_DRAW;    // Nothing to erase yet
                            end else begin
                                fill_y <= fill_y + 1'b1;
                            end
                        end else begin
                            fill_x <= fill_x + 1'b1;
                        end
                    end
                end

                S_ERASE, S_DRAW: begin
                    if (accept) begin
                        if (dx != offset_t'(TILE_SIZE - 1)) begin
                            dx <= dx + 1'b1;
                        end else begin
                            dx <= '0;
                            if (!block_last) begin
                                dy <= dy + 1'b1;
                            end else begin
                                dy  <= '0;
                                obj <= obj + 1'b1;    // Wraps back to the player
                                if (obj == object_t'(3))
                                    state <= (state == S_ERASE) ? S_DRAW : S_DRAIN;
                            end
                        end
                    end
                end

                S_DRAIN: begin
                    if (pipe_empty)
                        state <= S_FINISH;
                end

                S_FINISH: state <= S_IDLE;

                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == S_IDLE && start) begin
            cur_x <= pos_x_in;
            cur_y <= pos_y_in;
        end
        if (state == S_FINISH) begin
            prev_x <= cur_x;    // Next frame erases these blocks
            prev_y <= cur_y;
        end
    end

endmodule

/* hdl/pixel_pipe.sv */
`timescale 1ns/1ns

module pixel_pipe import render_pkg::*; #(
    parameter int CREDITS = 4
) (
    input  logic     clock,
    input  logic     resetn,
    input  logic     req_valid,
    input  pixel_x_t req_x,
    input  pixel_y_t req_y,
    input  source_t  req_source,
    input  color_t   bg_color,
    input  color_t   sprite_color,
    input  logic     pixel_credit,
    output logic     req_ready,
    output logic     pipe_empty,
    output logic     pixel_valid,
    output pixel_x_t pixel_x,
    output pixel_y_t pixel_y,
    output color_t   pixel_color
);

    localparam int CW = $clog2(CREDITS + 1);

    logic          accept;
    logic          s1_valid;        // Request waiting on the ROM read
    pixel_x_t      s1_x;
    pixel_y_t      s1_y;
    source_t       s1_source;
    logic [CW-1:0] credit_count;    // Space left in the frame buffer
    logic [CW-1:0] in_flight;       // Accepted but not yet charged

    // In-flight pixels are already paid for, so only new requests wait
    assign req_ready  = (credit_count > in_flight);
    assign accept     = req_valid && req_ready;
    assign pipe_empty = (in_flight == '0);

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            s1_valid    <= 1'b0;
            pixel_valid <= 1'b0;
        end else begin
            s1_valid    <= accept;
            pixel_valid <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        s1_x      <= req_x;
        s1_y      <= req_y;
        s1_source <= req_source;
        pixel_x   <= s1_x;
        pixel_y   <= s1_y;
        pixel_color <= (s1_source == SRC_BACKGROUND) ? bg_color : sprite_color;
    end

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn) begin
            credit_count <= CW'(CREDITS);
            in_flight    <= '0;
        end else begin
            case ({pixel_valid, pixel_credit})
                2'b10:   credit_count <= credit_count - 1'b1;    // Spent on output
                2'b01:   credit_count <= credit_count + 1'b1;    // Returned by sink
                default: credit_count <= credit_count;
            endcase

            case ({accept, pixel_valid})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;
            endcase
        end
    end

endmodule

/* hdl/sprite_rom.sv */
`timescale 1ns/1ns

module sprite_rom import render_pkg::*; (
    input  logic    clock,
    input  logic    resetn,
    input  source_t req_source,
    input  offset_t req_dx,
    input  offset_t req_dy,
    output color_t  sprite_color
);

    // Rows are indexed by dy, columns by dx
    localparam color_t PLAYER_BITMAP [0:4][0:4] = '{
        '{12'hF00, 12'hFF3, 12'hFF3, 12'h000, 12'hFF3},
        '{12'hFF3, 12'hFF3, 12'hFF3, 12'hFF3, 12'hFF3},
        '{12'hFF3, 12'hFF3, 12'hFF3, 12'hFF3, 12'hFF3},
        '{12'h000, 12'h000, 12'hFF3, 12'hFF3, 12'hFF3},
        '{12'hFF3, 12'hFF3, 12'hFF3, 12'h000, 12'hF00}
    };

    localparam color_t GHOST_BITMAP [0:4][0:4] = '{
        '{12'h000, 12'h000, 12'hFFF, 12'h000, 12'h000},
        '{12'h000, 12'hFFF, 12'hFFF, 12'hFFF, 12'h000},
        '{12'hFFF, 12'hFFF, 12'hF00, 12'hFFF, 12'hFFF},    // Red eye in the middle
        '{12'hFFF, 12'hFFF, 12'hFFF, 12'hFFF, 12'hFFF},
        '{12'hFFF, 12'h000, 12'hFFF, 12'h000, 12'hFFF}
    };

    color_t color_next;

    always_comb begin
        if (req_source == SRC_GHOST)
            color_next = GHOST_BITMAP[req_dy][req_dx];
        else
            color_next = PLAYER_BITMAP[req_dy][req_dx];
    end

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn)
            sprite_color <= COLOR_FLOOR;
        else
            sprite_color <= color_next;
    end

endmodule

/* hdl/background_rom.sv */
`timescale 1ns/1ns

module background_rom import render_pkg::*; (
    input  logic     clock,
    input  logic     resetn,
    input  pixel_x_t req_x,
    input  pixel_y_t req_y,
    output color_t   bg_color
);

    tile_x_t tile_x;
    tile_y_t tile_y;
    offset_t off_x;
    offset_t off_y;
    logic    border;
    logic    pillar;
    logic    pellet;
    color_t  color_next;

    // Split the pixel into tile and offset inside the tile
    assign tile_x = tile_x_t'(req_x / TILE_SIZE);
    assign tile_y = tile_y_t'(req_y / TILE_SIZE);
    assign off_x  = offset_t'(req_x % TILE_SIZE);
    assign off_y  = offset_t'(req_y % TILE_SIZE);

    assign border = (tile_x == tile_x_t'(0)) || (tile_x == tile_x_t'(BOARD_W - 1)) ||
                    (tile_y == tile_y_t'(0)) || (tile_y == tile_y_t'(BOARD_H - 1));

    // Inner wall blocks on a 4-tile grid
    assign pillar = (tile_x[1:0] == 2'd2) && (tile_y[1:0] == 2'd2);

    assign pellet = (off_x == offset_t'(2)) && (off_y == offset_t'(2));    // Tile centre

    always_comb begin
        if (border || pillar)
            color_next = COLOR_WALL;
        else if (pellet)
            color_next = COLOR_PELLET;
        else
            color_next = COLOR_FLOOR;
    end

    always_ff @(posedge clock or negedge resetn) begin
        if (!resetn)
            bg_color <= COLOR_FLOOR;
        else
            bg_color <= color_next;
    end

endmodule

/* hdl/render_pkg.sv */
package render_pkg;

    // Screen and board geometry
    parameter int SCREEN_W  = 160;
    parameter int SCREEN_H  = 120;
    parameter int TILE_SIZE = 5;     // Tile edge in pixels
    parameter int BOARD_W   = 32;
    parameter int BOARD_H   = 24;

    typedef logic [7:0]  pixel_x_t;
    typedef logic [6:0]  pixel_y_t;
    typedef logic [4:0]  tile_x_t;
    typedef logic [4:0]  tile_y_t;
    typedef logic [11:0] color_t;    // 4 bits each of R, G, B
    typedef logic [2:0]  offset_t;   // 0 to 4 inside a tile

    // 0 is the player, 1 to 3 the ghosts
    typedef logic [1:0]  object_t;

    // Where a pixel takes its colour from
    typedef enum logic [1:0] {
        SRC_BACKGROUND = 2'd0,
        SRC_PLAYER     = 2'd1,
        SRC_GHOST      = 2'd2
    } source_t;

    // Maze colours
    parameter color_t COLOR_WALL   = 12'h00F;
    parameter color_t COLOR_FLOOR  = 12'h000;
    parameter color_t COLOR_PELLET = 12'hFF0;

endpackage
